/* hdl/daq_defs.svh */
`ifndef DAQ_DEFS_SVH
`define DAQ_DEFS_SVH

// --------------------------------------------------
// bus geometry
// --------------------------------------------------

// external bus address lines
`define DAQ_ADDR_W 19

// --------------------------------------------------
// fifo sizing
// --------------------------------------------------

// command fifo holds full 80-bit commands
`define CMD_FIFO_DEPTH 8
// sample fifo holds 16-bit ramp values
`define SAMPLE_FIFO_DEPTH 32

// almost flags rise this many entries from the edge
`define FIFO_MARGIN 2

`endif

/* hdl/ebi_pkg.sv */
`default_nettype none

package ebi_pkg;

  `include "daq_defs.svh"

  // --------------------------------------------------
  // register map seen by the host
  // --------------------------------------------------
  typedef enum logic [`DAQ_ADDR_W-1:0] {
    STATUS      = 0,
    CMD_W1      = 1,
    CMD_W2      = 2,
    CMD_W3      = 3,
    CMD_W4      = 4,
    CMD_W5      = 5,
    NEXT_SAMPLE = 6,
    RESET_TIME  = 7,
    RUN_TIME    = 8,
    TIME_L      = 9,
    TIME_H      = 10
  } ebi_addr_e;

  // status word, msb first
  typedef struct packed {
    logic       cmd_almost_full;
    logic       cmd_full;
    logic       cmd_almost_empty;
    logic       cmd_empty;
    logic       sample_almost_full;
    logic       sample_full;
    logic       sample_almost_empty;
    logic       sample_empty;
    logic       sample_ready;
    logic       time_running;
    // always read as zero
    logic [5:0] reserved;
  } ebi_status_t;

endpackage

`default_nettype wire

/* hdl/cmd_pkg.sv */
`default_nettype none

package cmd_pkg;

  // --------------------------------------------------
  // command opcodes
  // --------------------------------------------------
  // anything not listed behaves as nop
  typedef enum logic [3:0] {
    NOP      = 4'd0,
    RAMP_NOW = 4'd1,
    RAMP_AT  = 4'd2
  } cmd_opcode_e;

  // --------------------------------------------------
  // 80-bit command layout
  // --------------------------------------------------
  // msb first, bus word 5 on top
  typedef struct packed {
    // word 5
    logic [15:0] step;
    // word 4
    logic [15:0] start;
    // words 3 (high) and 2 (low)
    logic [31:0] trigger_time;
    // word 1, count above opcode
    logic [11:0] count;
    cmd_opcode_e opcode;
  } cmd_fields_t;

  // same 80 bits, two ways of looking at them
  // words[0] is bus word 1
  typedef union packed {
    cmd_fields_t       fields;
    logic [4:0][15:0]  words;
  } cmd_word_u;

endpackage

`default_nettype wire

/* hdl/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "daq_defs.svh"

module sync_fifo #(
  parameter int WIDTH = 16,
  parameter int DEPTH = 32
) (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             wr_en,
  input  wire logic [WIDTH-1:0] wdata,
  input  wire logic             rd_en,
  output logic      [WIDTH-1:0] rdata,
  output logic                  full,
  output logic                  empty,
  output logic                  almost_full,
  output logic                  almost_empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // storage, no reset needed on payload
  logic [WIDTH-1:0] mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic do_push;
  logic do_pop;

  // wrap pointer at depth, works for any depth
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // requests blocked by their flag are dropped
  assign do_push = wr_en & ~full;
  assign do_pop  = rd_en & ~empty;

  // --------------------------------------------------
  // storage write
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  // --------------------------------------------------
  // pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // push and pop together leave count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head entry always visible
  assign rdata = mem[rd_ptr];

  // flags straight from occupancy
  assign full         = (count == CNT_W'(DEPTH));
  assign empty        = (count == '0);
  assign almost_full  = (count >= CNT_W'(DEPTH - `FIFO_MARGIN));
  assign almost_empty = (count <= CNT_W'(`FIFO_MARGIN));

endmodule

`default_nettype wire

/* hdl/ebi_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "daq_defs.svh"

module ebi_bridge (
  input  wire logic                   clk,
  input  wire logic                   rst,
  // host bus
  input  wire logic [15:0]            data_in,
  input  wire logic [`DAQ_ADDR_W-1:0] addr,
  input  wire logic                   rd,
  input  wire logic                   wr,
  input  wire logic                   cs,
  output logic      [15:0]            data_out,
  output logic                        irq,
  output logic      [31:0]            global_clock,
  // command fifo write side
  output cmd_pkg::cmd_word_u          cmd_wdata,
  output logic                        cmd_wr_en,
  input  wire logic [3:0]             cmd_flags,
  // sample fifo read side
  input  wire logic [15:0]            sample_rdata,
  output logic                        sample_rd_en,
  input  wire logic [3:0]             sample_flags
);

  import ebi_pkg::*;

  // flag vectors are {almost_full, full, almost_empty, empty}
  localparam logic [1:0] ST_IDLE           = 2'd0;
  localparam logic [1:0] ST_FETCH          = 2'd1;
  localparam logic [1:0] ST_FIFO_READ      = 2'd2;
  localparam logic [1:0] ST_FIFO_READ_NEXT = 2'd3;

  logic [1:0] state;
  logic [1:0] next_state;

  // delayed strobes for end-of-transaction detect
  logic rd_d;
  logic rd_dd;
  logic wr_d;
  logic wr_dd;
  logic rd_done;
  logic wr_done;

  ebi_addr_e   last_wr_addr;
  logic        sample_read;
  logic        sample_clear;
  logic        reset_time;
  logic        run_time;
  logic        time_running;

  // prefetch register
  logic [15:0] sample_data;
  logic        sample_valid;

  ebi_status_t status;
  ebi_status_t status_ack;

  // host currently reading the sample register
  assign sample_read = cs & rd & (addr == NEXT_SAMPLE);

  // --------------------------------------------------
  // strobe falling edge detect
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_d  <= 1'b0;
      rd_dd <= 1'b0;
      wr_d  <= 1'b0;
      wr_dd <= 1'b0;
    end else begin
      rd_d  <= rd & cs;
      rd_dd <= rd_d;
      wr_d  <= wr & cs;
      wr_dd <= wr_d;
    end
  end

  // high one cycle once the strobe has dropped
  assign rd_done = rd_dd & ~rd_d;
  assign wr_done = wr_dd & ~wr_d;

  // --------------------------------------------------
  // control fsm
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state   = state;
    cmd_wr_en    = 1'b0;
    sample_rd_en = 1'b0;
    sample_clear = 1'b0;
    reset_time   = 1'b0;
    run_time     = 1'b0;
    case (state)
      ST_IDLE: begin
        next_state = ST_FETCH;
      end
      ST_FETCH: begin
        // full command goes out once word 5 write ends
        if (wr_done && last_wr_addr == CMD_W5) begin
          cmd_wr_en = 1'b1;
        end
        if (cs && wr) begin
          if (addr == RESET_TIME) begin
            reset_time = 1'b1;
          end else if (addr == RUN_TIME) begin
            run_time = 1'b1;
          end
        end
        // refill held off while host reads the register
        if (sample_read) begin
          next_state = ST_FIFO_READ;
        end else if (!sample_valid && !sample_flags[0]) begin
          sample_rd_en = 1'b1;
        end
      end
      ST_FIFO_READ: begin
        // hold value until host drops rd
        if (rd_done) begin
          next_state = ST_FIFO_READ_NEXT;
        end
      end
      ST_FIFO_READ_NEXT: begin
        // host has its sample, free the register
        sample_clear = 1'b1;
        next_state   = ST_FETCH;
      end
      default: begin
        next_state = ST_IDLE;
      end
    endcase
  end

  // --------------------------------------------------
  // command word capture
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (cs && wr) begin
      case (addr)
        CMD_W1:  cmd_wdata.words[0] <= data_in;
        CMD_W2:  cmd_wdata.words[1] <= data_in;
        CMD_W3:  cmd_wdata.words[2] <= data_in;
        CMD_W4:  cmd_wdata.words[3] <= data_in;
        CMD_W5:  cmd_wdata.words[4] <= data_in;
        default: ;
      endcase
    end
  end

  // target of the most recent write
  always_ff @(posedge clk) begin
    if (rst) begin
      last_wr_addr <= STATUS;
    end else if (cs && wr) begin
      last_wr_addr <= ebi_addr_e'(addr);
    end
  end

  // --------------------------------------------------
  // global time counter
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      global_clock <= '0;
      time_running <= 1'b0;
    end else if (reset_time) begin
      // reset also stops time
      global_clock <= '0;
      time_running <= 1'b0;
    end else begin
      if (time_running) begin
        global_clock <= global_clock + 1'b1;
      end
      if (run_time) begin
        time_running <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // sample prefetch register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      sample_valid <= 1'b0;
    end else if (sample_clear) begin
      sample_valid <= 1'b0;
    end else if (sample_rd_en) begin
      sample_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (sample_rd_en) begin
      sample_data <= sample_rdata;
    end
  end

  // --------------------------------------------------
  // status and irq
  // --------------------------------------------------
  always_comb begin
    status                     = '0;
    status.cmd_almost_full     = cmd_flags[3];
    status.cmd_full            = cmd_flags[2];
    status.cmd_almost_empty    = cmd_flags[1];
    status.cmd_empty           = cmd_flags[0];
    status.sample_almost_full  = sample_flags[3];
    status.sample_full         = sample_flags[2];
    status.sample_almost_empty = sample_flags[1];
    status.sample_empty        = sample_flags[0];
    status.sample_ready        = sample_valid;
    status.time_running        = time_running;
  end

  // ack copy tracks status through reset so irq starts quiet
  always_ff @(posedge clk) begin
    if (rst) begin
      status_ack <= status;
      irq        <= 1'b0;
    end else begin
      irq <= (status != status_ack);
      if (cs && rd && addr == STATUS) begin
        status_ack <= status;
      end
    end
  end

  // --------------------------------------------------
  // read data
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      data_out <= '0;
    end else if (cs && rd) begin
      case (addr)
        STATUS:      data_out <= status;
        NEXT_SAMPLE: data_out <= sample_valid ? sample_data : 16'hDEAD;
        TIME_L:      data_out <= global_clock[15:0];
        TIME_H:      data_out <= global_clock[31:16];
        default:     data_out <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/ramp_executor.sv */
`timescale 1ns/1ps
`default_nettype none

module ramp_executor (
  input  wire logic               clk,
  input  wire logic               rst,
  // command fifo head
  input  wire cmd_pkg::cmd_word_u cmd,
  input  wire logic               cmd_empty,
  output logic                    cmd_rd_en,
  // sample fifo write side
  input  wire logic               sample_full,
  output logic      [15:0]        sample_wdata,
  output logic                    sample_wr_en,
  input  wire logic [31:0]        global_clock
);

  import cmd_pkg::*;

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_WAIT = 2'd1;
  localparam logic [1:0] ST_EMIT = 2'd2;

  logic [1:0]  state;

  // samples still to push
  logic [11:0] remaining;
  // current ramp value and increment
  logic [15:0] acc;
  logic [15:0] step;
  logic [31:0] trigger;

  logic        push;

  // pop whenever idle and a command waits
  assign cmd_rd_en    = (state == ST_IDLE) & ~cmd_empty;
  // stall on full, acc holds so nothing is lost
  assign push         = (state == ST_EMIT) & ~sample_full;
  assign sample_wr_en = push;
  assign sample_wdata = acc;

  // --------------------------------------------------
  // state and count
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_IDLE;
      remaining <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (cmd_rd_en) begin
            remaining <= cmd.fields.count;
            // zero-length ramps dropped like nop
            if (cmd.fields.count != '0) begin
              case (cmd.fields.opcode)
                RAMP_NOW: state <= ST_EMIT;
                RAMP_AT:  state <= ST_WAIT;
                default:  state <= ST_IDLE;
              endcase
            end
          end
        end
        ST_WAIT: begin
          // counter may be stopped, then we sit here
          if (global_clock >= trigger) begin
            state <= ST_EMIT;
          end
        end
        ST_EMIT: begin
          if (push) begin
            remaining <= remaining - 1'b1;
            if (remaining == 12'd1) begin
              state <= ST_IDLE;
            end
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // ramp datapath
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (cmd_rd_en) begin
      acc     <= cmd.fields.start;
      step    <= cmd.fields.step;
      trigger <= cmd.fields.trigger_time;
    end else if (push) begin
      // wraps mod 2^16
      acc <= acc + step;
    end
  end

endmodule

`default_nettype wire

/* hdl/daq_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "daq_defs.svh"

module daq_top (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic [15:0]            data_in,
  input  wire logic [`DAQ_ADDR_W-1:0] addr,
  input  wire logic                   rd,
  input  wire logic                   wr,
  input  wire logic                   cs,
  output logic      [15:0]            data_out,
  output logic                        irq,
  output logic      [31:0]            global_clock
);

  import cmd_pkg::*;

  // --------------------------------------------------
  // command path
  // --------------------------------------------------
  cmd_word_u   cmd_wdata;
  cmd_word_u   cmd_rdata;
  logic        cmd_wr_en;
  logic        cmd_rd_en;
  logic        cmd_full;
  logic        cmd_empty;
  logic        cmd_almost_full;
  logic        cmd_almost_empty;

  // --------------------------------------------------
  // sample path
  // --------------------------------------------------
  logic [15:0] sample_wdata;
  logic [15:0] sample_rdata;
  logic        sample_wr_en;
  logic        sample_rd_en;
  logic        sample_full;
  logic        sample_empty;
  logic        sample_almost_full;
  logic        sample_almost_empty;

  // host registers, time base, prefetch
  ebi_bridge u_bridge (
    .clk          (clk),
    .rst          (rst),
    .data_in      (data_in),
    .addr         (addr),
    .rd           (rd),
    .wr           (wr),
    .cs           (cs),
    .data_out     (data_out),
    .irq          (irq),
    .global_clock (global_clock),
    .cmd_wdata    (cmd_wdata),
    .cmd_wr_en    (cmd_wr_en),
    .cmd_flags    ({cmd_almost_full, cmd_full, cmd_almost_empty, cmd_empty}),
    .sample_rdata (sample_rdata),
    .sample_rd_en (sample_rd_en),
    .sample_flags ({sample_almost_full, sample_full, sample_almost_empty, sample_empty})
  );

  sync_fifo #(
    .WIDTH ($bits(cmd_word_u)),
    .DEPTH (`CMD_FIFO_DEPTH)
  ) u_cmd_fifo (
    .clk          (clk),
    .rst          (rst),
    .wr_en        (cmd_wr_en),
    .wdata        (cmd_wdata),
    .rd_en        (cmd_rd_en),
    .rdata        (cmd_rdata),
    .full         (cmd_full),
    .empty        (cmd_empty),
    .almost_full  (cmd_almost_full),
    .almost_empty (cmd_almost_empty)
  );

  sync_fifo #(
    .WIDTH (16),
    .DEPTH (`SAMPLE_FIFO_DEPTH)
  ) u_sample_fifo (
    .clk          (clk),
    .rst          (rst),
    .wr_en        (sample_wr_en),
    .wdata        (sample_wdata),
    .rd_en        (sample_rd_en),
    .rdata        (sample_rdata),
    .full         (sample_full),
    .empty        (sample_empty),
    .almost_full  (sample_almost_full),
    .almost_empty (sample_almost_empty)
  );

  // ramp source standing in for acquisition
  ramp_executor u_exec (
    .clk          (clk),
    .rst          (rst),
    .cmd          (cmd_rdata),
    .cmd_empty    (cmd_empty),
    .cmd_rd_en    (cmd_rd_en),
    .sample_full  (sample_full),
    .sample_wdata (sample_wdata),
    .sample_wr_en (sample_wr_en),
    .global_clock (global_clock)
  );

endmodule

`default_nettype wire

/* verif/daq_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module daq_properties (
  input wire logic clk,
  input wire logic rst,
  input wire logic cmd_wr_en,
  input wire logic cmd_rd_en,
  input wire logic cmd_full,
  input wire logic cmd_empty,
  input wire logic sample_wr_en,
  input wire logic sample_rd_en,
  input wire logic sample_full,
  input wire logic sample_empty
);

  // one count per rule, summed into a single flag
  int   push_full_cnt = 0;
  int   pop_empty_cnt = 0;
  int   cmd_pulse_cnt = 0;
  logic any_violation;

  assign any_violation = (push_full_cnt + pop_empty_cnt + cmd_pulse_cnt) != 0;

  // --------------------------------------------------
  // fifo rules
  // --------------------------------------------------
  push_not_full: assert property (@(posedge clk) disable iff (rst)
      !((cmd_wr_en && cmd_full) || (sample_wr_en && sample_full)))
    else begin
      push_full_cnt = push_full_cnt + 1;
      $error("push requested while fifo full");
    end

  pop_not_empty: assert property (@(posedge clk) disable iff (rst)
      !((cmd_rd_en && cmd_empty) || (sample_rd_en && sample_empty)))
    else begin
      pop_empty_cnt = pop_empty_cnt + 1;
      $error("pop requested while fifo empty");
    end

  // --------------------------------------------------
  // strobe rules
  // --------------------------------------------------
  // command push is a single-cycle pulse
  cmd_push_pulse: assert property (@(posedge clk) disable iff (rst)
      cmd_wr_en |=> !cmd_wr_en)
    else begin
      cmd_pulse_cnt = cmd_pulse_cnt + 1;
      $error("command push wider than one cycle");
    end

endmodule

bind daq_top daq_properties u_props (
  .clk          (clk),
  .rst          (rst),
  .cmd_wr_en    (cmd_wr_en),
  .cmd_rd_en    (cmd_rd_en),
  .cmd_full     (cmd_full),
  .cmd_empty    (cmd_empty),
  .sample_wr_en (sample_wr_en),
  .sample_rd_en (sample_rd_en),
  .sample_full  (sample_full),
  .sample_empty (sample_empty)
);

`default_nettype wire

/* verif/daq_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "daq_defs.svh"

module daq_tb;

  import ebi_pkg::*;
  import cmd_pkg::*;

  localparam int TIMEOUT   = 200;
  localparam int DRIVE_DLY = 2;

  logic                   clk;
  logic                   rst;
  logic [15:0]            data_in;
  logic [`DAQ_ADDR_W-1:0] addr;
  logic                   rd;
  logic                   wr;
  logic                   cs;
  logic [15:0]            data_out;
  logic                   irq;
  logic [31:0]            global_clock;

  // compares waiting for the checker
  string       name_q[$];
  logic [15:0] exp_q[$];
  logic [15:0] act_q[$];

  daq_top uut (
    .clk          (clk),
    .rst          (rst),
    .data_in      (data_in),
    .addr         (addr),
    .rd           (rd),
    .wr           (wr),
    .cs           (cs),
    .data_out     (data_out),
    .irq          (irq),
    .global_clock (global_clock)
  );

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  // sample k of a ramp, wraps mod 2^16
  function automatic logic [15:0] ramp_value(input logic [15:0] start,
                                             input logic [15:0] step, input int k);
    logic [31:0] prod;
    prod = 32'(k) * 32'(step);
    return start + prod[15:0];
  endfunction

  task automatic expect_value(input string name, input logic [15:0] exp_v,
                              input logic [15:0] act_v);
    name_q.push_back(name);
    exp_q.push_back(exp_v);
    act_q.push_back(act_v);
  endtask

  // --------------------------------------------------
  // bus cycles: 3 strobe cycles, then idle
  // --------------------------------------------------
  task automatic bus_write(input ebi_addr_e a, input logic [15:0] d);
    @(posedge clk);
    #(DRIVE_DLY);
    addr    = a;
    data_in = d;
    cs      = 1'b1;
    wr      = 1'b1;
    repeat (3) @(posedge clk);
    #(DRIVE_DLY);
    cs = 1'b0;
    wr = 1'b0;
    repeat (4) @(posedge clk);
  endtask

  task automatic bus_read(input ebi_addr_e a, output logic [15:0] d);
    @(posedge clk);
    #(DRIVE_DLY);
    addr = a;
    cs   = 1'b1;
    rd   = 1'b1;
    repeat (3) @(posedge clk);
    #(DRIVE_DLY);
    // data_out registered on the last strobe edge
    d  = data_out;
    cs = 1'b0;
    rd = 1'b0;
    repeat (4) @(posedge clk);
  endtask

  task automatic read_status(output ebi_status_t st);
    logic [15:0] raw;
    bus_read(STATUS, raw);
    st = ebi_status_t'(raw);
  endtask

  task automatic read_time(output logic [31:0] t);
    logic [15:0] lo;
    logic [15:0] hi;
    bus_read(TIME_L, lo);
    bus_read(TIME_H, hi);
    t = {hi, lo};
  endtask

  // word 1 is count over opcode, word 5 the step
  task automatic send_cmd(input cmd_opcode_e op, input logic [11:0] count,
                          input logic [31:0] trig, input logic [15:0] start,
                          input logic [15:0] step);
    bus_write(CMD_W1, {count, op});
    bus_write(CMD_W2, trig[15:0]);
    bus_write(CMD_W3, trig[31:16]);
    bus_write(CMD_W4, start);
    bus_write(CMD_W5, step);
  endtask

  task automatic wait_sample_ready(input string name);
    ebi_status_t st;
    int          tries;
    tries = 0;
    read_status(st);
    while (!st.sample_ready && tries < TIMEOUT) begin
      read_status(st);
      tries++;
    end
    assert (st.sample_ready)
      else abort_run($sformatf("%s: no sample became ready in time", name));
  endtask

  task automatic read_ramp(input string name, input logic [15:0] start,
                           input logic [15:0] step, input int count);
    logic [15:0] got;
    for (int k = 0; k < count; k++) begin
      wait_sample_ready(name);
      bus_read(NEXT_SAMPLE, got);
      expect_value($sformatf("%s[%0d]", name, k), ramp_value(start, step, k), got);
    end
  endtask

  // --------------------------------------------------
  // checker
  // --------------------------------------------------
  initial begin : compare
    string       name;
    logic [15:0] exp_v;
    logic [15:0] act_v;
    forever begin
      @(negedge clk);
      while (act_q.size() > 0) begin
        name  = name_q.pop_front();
        exp_v = exp_q.pop_front();
        act_v = act_q.pop_front();
        assert (act_v === exp_v)
          else abort_run($sformatf("Mismatch %s expected %h actual %h", name, exp_v, act_v));
      end
    end
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial begin : stimulus
    ebi_status_t st;
    logic [15:0] v;
    logic [15:0] start;
    logic [15:0] step;
    logic [31:0] t_prev;
    logic [31:0] t_now;
    logic [31:0] trig;
    int          count;
    int          tries;

    void'($urandom(32'h25a60441));
    rst     = 1'b1;
    cs      = 1'b0;
    rd      = 1'b0;
    wr      = 1'b0;
    addr    = '0;
    data_in = '0;
    repeat (16) @(posedge clk);
    #(DRIVE_DLY);
    rst = 1'b0;

    // idle state after reset
    assert (irq === 1'b0) else abort_run("irq high after reset");
    read_status(st);
    assert (st.cmd_empty && st.sample_empty) else abort_run("fifos not empty after reset");
    assert (!st.sample_ready && !st.time_running)
      else abort_run("sample_ready or time_running set after reset");
    bus_read(NEXT_SAMPLE, v);
    expect_value("reset_sample", 16'hDEAD, v);

    // immediate ramp, then a nop that yields nothing
    start = 16'($urandom);
    step  = 16'($urandom);
    count = $urandom_range(4, `SAMPLE_FIFO_DEPTH - 1);
    send_cmd(RAMP_NOW, 12'(count), 32'h0, start, step);
    read_ramp("ramp_now", start, step, count);
    send_cmd(NOP, 12'd5, 32'h0, 16'h1234, 16'h0001);
    read_status(st);
    assert (st.cmd_empty) else abort_run("nop command stayed in the command fifo");
    bus_read(NEXT_SAMPLE, v);
    expect_value("nop_sample", 16'hDEAD, v);

    // time counter run and reset
    bus_write(RUN_TIME, 16'h0);
    read_time(t_prev);
    for (int i = 0; i < 4; i++) begin
      read_time(t_now);
      assert (t_now > t_prev)
        else abort_run($sformatf("time did not increase, %0d then %0d", t_prev, t_now));
      // live counter keeps running past the last bus snapshot
      assert (global_clock > t_now)
        else abort_run($sformatf("global_clock %0d not past bus time %0d",
                                 global_clock, t_now));
      t_prev = t_now;
    end
    bus_write(RESET_TIME, 16'h0);
    for (int i = 0; i < 2; i++) begin
      read_time(t_now);
      expect_value("time_reset_lo", 16'h0, t_now[15:0]);
      expect_value("time_reset_hi", 16'h0, t_now[31:16]);
      // stopped counter stays at zero on the output too
      expect_value("global_clock_lo", 16'h0, global_clock[15:0]);
      expect_value("global_clock_hi", 16'h0, global_clock[31:16]);
    end

    // triggered ramp held while time is stopped
    trig  = 32'd300 + 32'($urandom_range(0, 200));
    start = 16'($urandom);
    step  = 16'($urandom);
    send_cmd(RAMP_AT, 12'd6, trig, start, step);
    for (int i = 0; i < 10; i++) begin
      read_status(st);
      assert (!st.sample_ready && st.sample_empty)
        else abort_run("triggered ramp produced a sample with time stopped");
    end
    bus_write(RUN_TIME, 16'h0);
    wait_sample_ready("ramp_at");
    read_time(t_now);
    assert (t_now >= trig)
      else abort_run($sformatf("first sample before trigger, time %0d trigger %0d", t_now, trig));
    read_ramp("ramp_at", start, step, 6);

    // longer than the sample fifo, executor must stall
    start = 16'($urandom);
    step  = 16'($urandom);
    send_cmd(RAMP_NOW, 12'd60, 32'h0, start, step);
    tries = 0;
    read_status(st);
    while (!st.sample_full && tries < TIMEOUT) begin
      read_status(st);
      tries++;
    end
    assert (st.sample_full) else abort_run("sample fifo never filled on long ramp");
    read_ramp("backpressure", start, step, 60);

    // irq on status change, cleared by status read
    read_status(st);
    assert (irq === 1'b0) else abort_run("irq still high after status read");
    start = 16'($urandom);
    step  = 16'($urandom);
    send_cmd(RAMP_NOW, 12'd3, 32'h0, start, step);
    tries = 0;
    while (irq !== 1'b1 && tries < TIMEOUT) begin
      @(posedge clk);
      #(DRIVE_DLY);
      tries++;
    end
    assert (irq === 1'b1) else abort_run("irq did not rise when samples arrived");
    wait_sample_ready("irq_ramp");
    read_status(st);
    assert (irq === 1'b0) else abort_run("irq stayed high after status read");
    read_ramp("irq_ramp", start, step, 3);

    // let the checker empty its queue
    tries = 0;
    while (act_q.size() > 0 && tries < TIMEOUT) begin
      @(posedge clk);
      tries++;
    end
    assert (act_q.size() == 0) else abort_run("compare queue did not drain");
    if (uut.u_props.any_violation) begin
      abort_run("bound assertion reported a violation");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+hdl
hdl/ebi_pkg.sv
hdl/cmd_pkg.sv
hdl/sync_fifo.sv
hdl/ebi_bridge.sv
hdl/ramp_executor.sv
hdl/daq_top.sv
verif/daq_properties.sv
verif/daq_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build daq_tb with verilator, run it, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module daq_tb -f flist.f -o daq_sim
	./obj_dir/daq_sim +verilator+error+limit+100 | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
